// File: hw/mcu_macros.svh
// ====================
// Widths are fixed by the J1 I/O strobe bus and the Wishbone master
// MCU_BIT_PERIOD is a simulation rate, raise it for real baud rates
// MCU_NIRQ and MCU_VEC_W must agree (vector 0 means no interrupt)
// ====================
`ifndef MCU_MACROS_SVH
`define MCU_MACROS_SVH

// CPU side
`define MCU_WIDTH      18   // Stack CPU cell width
`define MCU_IO_AW      4    // I/O register address bits

// Wishbone side
`define MCU_WB_AW      8    // Byte of address space
`define MCU_WB_DW      16   // Data width of the scratch peripheral

// UART
`define MCU_BIT_PERIOD 8    // Clocks per bit, at least 2

// Interrupts
`define MCU_NIRQ       3    // tx ready, rx full, wb done
`define MCU_VEC_W      2    // Enough for NIRQ plus the zero vector

`endif

// File: hw/mcu_pkg.sv
// ====================
// Register map and FSM encodings for the I/O subsystem
// Addresses above IRQ_PEND read as zero
// ====================
`include "mcu_macros.svh"

package mcu_pkg;

  // CPU I/O register addresses
  typedef enum logic [`MCU_IO_AW-1:0] {
    UART_DATA = 0,  // Write sends, read pops
    UART_STAT = 1,  // bit0 tx ready, bit1 rx full
    WB_ADDR   = 2,
    WB_DATA   = 3,  // Write data, read result after a read cycle
    WB_CTRL   = 4,  // Write starts a cycle, bit0 selects write
    WB_STAT   = 5,  // bit0 busy
    IRQ_EN    = 6,  // Write only
    IRQ_PEND  = 7
  } io_reg_e;

  // Shared by UART transmitter and receiver
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_e;

  // Wishbone master
  typedef enum logic {
    WB_IDLE,
    WB_BUSY
  } wb_state_e;

endpackage

// File: hw/mcu_ifs.sv
// ====================
// Byte stream between UART and register block, Wishbone classic bus
// No clock in either, both sides share the system clock
// ====================
`timescale 1ns/1ps
`include "mcu_macros.svh"

interface byte_stream_if;
  logic       tx_ready;  // Transmitter can take a byte
  logic       tx_wr;     // Byte offered, dropped if not ready
  logic [7:0] tx_data;
  logic       rx_full;   // Held until rx_rd
  logic [7:0] rx_data;   // Stable while rx_full
  logic       rx_rd;     // Pop strobe

  modport uart (output tx_ready, rx_full, rx_data, input tx_wr, tx_data, rx_rd);
  modport regs (input tx_ready, rx_full, rx_data, output tx_wr, tx_data, rx_rd);
endinterface

interface wb_if;
  logic [`MCU_WB_AW-1:0] adr;
  logic [`MCU_WB_DW-1:0] dat_w;  // Master to slave
  logic [`MCU_WB_DW-1:0] dat_r;  // Slave to master
  logic                  we;
  logic                  cyc;
  logic                  stb;
  logic                  ack;

  // Classic cycles only, no stall or err
  modport master (output adr, dat_w, we, cyc, stb, input dat_r, ack);
  modport slave (input adr, dat_w, we, cyc, stb, output dat_r, ack);
endinterface

// File: hw/uart.sv
// ====================
// 8N1 UART, fixed bit period, no parity and no framing error flag
// rxd_i may be asynchronous, a byte arriving while full is lost
// ====================
`timescale 1ns/1ps
`include "mcu_macros.svh"

module uart (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rxd_i,  // Async serial in
  output logic        txd_o,  // Idles high
  byte_stream_if.uart bs
);

  localparam int BP = `MCU_BIT_PERIOD;
  localparam int CW = $clog2(BP);

  mcu_pkg::uart_state_e tx_state;
  logic [CW-1:0]        tx_cnt;    // Clocks within a bit
  logic [2:0]           tx_bit;    // Data bit index
  logic [7:0]           tx_shift;  // LSB goes out first
  logic                 tx_end;

  mcu_pkg::uart_state_e rx_state;
  logic [CW-1:0]        rx_cnt;
  logic [2:0]           rx_bit;
  logic [7:0]           rx_shift;
  logic                 rx_meta;   // First sync flop
  logic                 rx_sync;   // Safe to use
  logic                 rx_end;
  logic                 rx_full_q;
  logic [7:0]           rx_data_q;

  assign tx_end      = (tx_cnt == CW'(BP - 1));
  assign rx_end      = (rx_cnt == CW'(BP - 1));
  assign bs.tx_ready = (tx_state == mcu_pkg::IDLE);  // Low from accept to end of stop
  assign bs.rx_full  = rx_full_q;
  assign bs.rx_data  = rx_data_q;

  // Transmitter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_state <= mcu_pkg::IDLE;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      tx_shift <= '0;
      txd_o    <= 1'b1;
    end else begin
      tx_cnt <= tx_end ? '0 : tx_cnt + 1'b1;
      case (tx_state)
        mcu_pkg::IDLE: begin
          tx_cnt <= '0;
          if (bs.tx_wr) begin             // Ready is implied in IDLE
            tx_shift <= bs.tx_data;
            txd_o    <= 1'b0;             // Start bit
            tx_state <= mcu_pkg::START;
          end
        end
        mcu_pkg::START: if (tx_end) begin
          txd_o    <= tx_shift[0];
          tx_shift <= tx_shift >> 1;
          tx_bit   <= '0;
          tx_state <= mcu_pkg::DATA;
        end
        mcu_pkg::DATA: if (tx_end) begin
          if (tx_bit == 3'd7) begin
            txd_o    <= 1'b1;             // Stop bit
            tx_state <= mcu_pkg::STOP;
          end else begin
            txd_o    <= tx_shift[0];
            tx_shift <= tx_shift >> 1;
            tx_bit   <= tx_bit + 1'b1;
          end
        end
        mcu_pkg::STOP: if (tx_end) tx_state <= mcu_pkg::IDLE;
        default: tx_state <= mcu_pkg::IDLE;
      endcase
    end
  end

  // Receiver, sampled at mid-bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta   <= 1'b1;
      rx_sync   <= 1'b1;
      rx_state  <= mcu_pkg::IDLE;
      rx_cnt    <= '0;
      rx_bit    <= '0;
      rx_shift  <= '0;
      rx_full_q <= 1'b0;
      rx_data_q <= '0;
    end else begin
      rx_meta <= rxd_i;
      rx_sync <= rx_meta;
      if (bs.rx_rd) rx_full_q <= 1'b0;    // Pop
      rx_cnt <= rx_end ? '0 : rx_cnt + 1'b1;
      case (rx_state)
        mcu_pkg::IDLE: begin
          rx_cnt <= '0;
          if (!rx_sync) rx_state <= mcu_pkg::START;  // Falling edge
        end
        mcu_pkg::START: if (rx_cnt == CW'(BP / 2 - 1)) begin
          rx_cnt   <= '0;                 // Realign to mid-bit
          rx_bit   <= '0;
          rx_state <= rx_sync ? mcu_pkg::IDLE : mcu_pkg::DATA;  // Glitch rejected
        end
        mcu_pkg::DATA: if (rx_end) begin
          rx_shift <= {rx_sync, rx_shift[7:1]};
          rx_bit   <= rx_bit + 1'b1;
          if (rx_bit == 3'd7) rx_state <= mcu_pkg::STOP;
        end
        mcu_pkg::STOP: if (rx_end) begin  // Middle of stop bit
          rx_state <= mcu_pkg::IDLE;
          if (!rx_full_q) begin           // Else the new byte is dropped
            rx_full_q <= 1'b1;
            rx_data_q <= rx_shift;
          end
        end
        default: rx_state <= mcu_pkg::IDLE;
      endcase
    end
  end

endmodule

// File: hw/io_regs.sv
// ====================
// CPU I/O register block, reads are registered one cycle late
// WB_ADDR and WB_DATA writes are ignored while a cycle is busy
// ====================
`timescale 1ns/1ps
`include "mcu_macros.svh"

module io_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  io_rd_i,
  input  logic                  io_wr_i,
  input  logic [`MCU_IO_AW-1:0] io_addr_i,
  input  logic [`MCU_WIDTH-1:0] io_din_i,
  output logic [`MCU_WIDTH-1:0] io_dout_o,   // Held until next read
  byte_stream_if.regs           bs,
  wb_if.master                  wb,
  output logic                  src_tx_o,    // Interrupt source strobes
  output logic                  src_rx_o,
  output logic                  src_wb_o,
  output logic                  irq_en_wr_o,
  output logic [`MCU_NIRQ-1:0]  irq_en_o,
  input  logic [`MCU_NIRQ-1:0]  irq_pend_i
);

  localparam int W = `MCU_WIDTH;

  mcu_pkg::io_reg_e      reg_sel;
  mcu_pkg::wb_state_e    wb_state;
  logic [`MCU_WB_AW-1:0] wb_adr_q;
  logic [`MCU_WB_DW-1:0] wb_data_q;   // Write data or read result
  logic                  wb_we_q;
  logic                  wb_busy;
  logic                  tx_ready_d;  // For edge detect
  logic                  rx_full_d;
  logic [W-1:0]          rd_mux;

  assign reg_sel = mcu_pkg::io_reg_e'(io_addr_i);
  assign wb_busy = (wb_state == mcu_pkg::WB_BUSY);

  // UART side
  assign bs.tx_wr   = io_wr_i && (reg_sel == mcu_pkg::UART_DATA);
  assign bs.tx_data = io_din_i[7:0];
  assign bs.rx_rd   = io_rd_i && (reg_sel == mcu_pkg::UART_DATA);  // Read pops

  // Enable register lives in irq_ctrl
  assign irq_en_wr_o = io_wr_i && (reg_sel == mcu_pkg::IRQ_EN);
  assign irq_en_o    = io_din_i[`MCU_NIRQ-1:0];

  // cyc and stb together for the whole cycle
  assign wb.adr   = wb_adr_q;
  assign wb.dat_w = wb_data_q;
  assign wb.we    = wb_we_q;
  assign wb.cyc   = wb_busy;
  assign wb.stb   = wb_busy;

  assign src_tx_o = bs.tx_ready & ~tx_ready_d;  // Rising edges only
  assign src_rx_o = bs.rx_full & ~rx_full_d;
  assign src_wb_o = wb.ack & wb_busy;           // Ack is one cycle wide

  always_comb begin
    rd_mux = '0;
    case (reg_sel)
      mcu_pkg::UART_DATA: rd_mux = W'(bs.rx_data);
      mcu_pkg::UART_STAT: rd_mux = W'({bs.rx_full, bs.tx_ready});
      mcu_pkg::WB_ADDR:   rd_mux = W'(wb_adr_q);
      mcu_pkg::WB_DATA:   rd_mux = W'(wb_data_q);
      mcu_pkg::WB_CTRL:   rd_mux = W'(wb_we_q);
      mcu_pkg::WB_STAT:   rd_mux = W'(wb_busy);
      mcu_pkg::IRQ_PEND:  rd_mux = W'(irq_pend_i);
      default:            rd_mux = '0;  // IRQ_EN and unmapped
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      io_dout_o  <= '0;
      tx_ready_d <= 1'b1;  // No tx strobe out of reset
      rx_full_d  <= 1'b0;
    end else begin
      tx_ready_d <= bs.tx_ready;
      rx_full_d  <= bs.rx_full;
      if (io_rd_i) io_dout_o <= rd_mux;
    end
  end

  // Wishbone master
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_state  <= mcu_pkg::WB_IDLE;
      wb_adr_q  <= '0;
      wb_data_q <= '0;
      wb_we_q   <= 1'b0;
    end else begin
      case (wb_state)
        mcu_pkg::WB_IDLE: begin
          if (io_wr_i && reg_sel == mcu_pkg::WB_ADDR) wb_adr_q <= io_din_i[`MCU_WB_AW-1:0];
          if (io_wr_i && reg_sel == mcu_pkg::WB_DATA) wb_data_q <= io_din_i[`MCU_WB_DW-1:0];
          if (io_wr_i && reg_sel == mcu_pkg::WB_CTRL) begin
            wb_we_q  <= io_din_i[0];
            wb_state <= mcu_pkg::WB_BUSY;  // cyc/stb next cycle
          end
        end
        mcu_pkg::WB_BUSY: if (wb.ack) begin
          if (!wb_we_q) wb_data_q <= wb.dat_r;  // Read result
          wb_state <= mcu_pkg::WB_IDLE;         // Busy drops after ack
        end
        default: wb_state <= mcu_pkg::WB_IDLE;
      endcase
    end
  end

endmodule

// File: hw/irq_ctrl.sv
// ====================
// Pending bit n-1 belongs to vector n and the highest vector wins
// A source strobe beats an acknowledge of the same bit
// ====================
`timescale 1ns/1ps
`include "mcu_macros.svh"

module irq_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`MCU_NIRQ-1:0]  src_i,    // Single-cycle strobes
  input  logic                  en_wr_i,
  input  logic [`MCU_NIRQ-1:0]  en_i,
  input  logic                  iack_i,   // Clears current vector
  output logic [`MCU_NIRQ-1:0]  pend_o,
  output logic                  irq_o,
  output logic [`MCU_VEC_W-1:0] ivec_o    // 0 when nothing pending
);

  localparam int N  = `MCU_NIRQ;
  localparam int VW = `MCU_VEC_W;

  logic [N-1:0] pend_q;
  logic [N-1:0] en_q;
  logic [N-1:0] act;   // Pending and enabled
  logic [N-1:0] clr;   // One-hot ack clear

  assign act    = pend_q & en_q;
  assign pend_o = pend_q;
  assign irq_o  = |act;  // Any source pending and enabled

  // Priority encoder where later hits override earlier ones
  always_comb begin
    ivec_o = '0;
    for (int i = 0; i < N; i++) begin
      if (act[i]) ivec_o = VW'(i + 1);
    end
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      clr[i] = iack_i && (ivec_o == VW'(i + 1));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= '0;
      en_q   <= '0;
    end else begin
      if (en_wr_i) en_q <= en_i;
      pend_q <= (pend_q & ~clr) | src_i;  // Set wins over clear
    end
  end

endmodule

// File: hw/wb_scratch.sv
// ====================
// Two scratch registers on adr[0], other upper bits read inverted
// Ack comes one cycle after stb, classic cycles only
// ====================
`timescale 1ns/1ps
`include "mcu_macros.svh"

module wb_scratch (
  input  logic  clk,
  input  logic  rst_n,
  wb_if.slave   wb
);

  logic [`MCU_WB_DW-1:0] regs [2];
  logic                  ack_q;
  logic                  sel;    // Register select
  logic                  upper;  // Any upper address bit set

  assign sel      = wb.adr[0];
  assign upper    = |wb.adr[`MCU_WB_AW-1:1];
  assign wb.dat_r = upper ? ~regs[sel] : regs[sel];  // Distinct alias view
  assign wb.ack   = ack_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q   <= 1'b0;
      regs[0] <= '0;
      regs[1] <= '0;
    end else begin
      ack_q <= wb.cyc & wb.stb & ~ack_q;  // Delayed stb, one pulse per cycle
      if (wb.cyc && wb.stb && wb.we && !ack_q) regs[sel] <= wb.dat_w;  // Write once
    end
  end

endmodule

// File: hw/mcu_io.sv
// ====================
// I/O side of the MCU, CPU not included
// The I/O strobe bus is driven from outside at the plain ports
// ====================
`timescale 1ns/1ps
`include "mcu_macros.svh"

module mcu_io (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  io_rd_i,    // CPU read strobe
  input  logic                  io_wr_i,    // CPU write strobe
  input  logic [`MCU_IO_AW-1:0] io_addr_i,
  input  logic [`MCU_WIDTH-1:0] io_din_i,
  output logic [`MCU_WIDTH-1:0] io_dout_o,  // Valid the cycle after io_rd_i
  input  logic                  iack_i,
  output logic                  irq_o,
  output logic [`MCU_VEC_W-1:0] ivec_o,
  input  logic                  rxd_i,      // Async
  output logic                  txd_o
);

  byte_stream_if bs ();
  wb_if          wb ();

  logic                 src_tx;
  logic                 src_rx;
  logic                 src_wb;
  logic                 irq_en_wr;
  logic [`MCU_NIRQ-1:0] irq_en;
  logic [`MCU_NIRQ-1:0] irq_pend;

  uart u_uart (
    .clk   (clk),
    .rst_n (rst_n),
    .rxd_i (rxd_i),
    .txd_o (txd_o),
    .bs    (bs)
  );

  io_regs u_io_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .io_rd_i     (io_rd_i),
    .io_wr_i     (io_wr_i),
    .io_addr_i   (io_addr_i),
    .io_din_i    (io_din_i),
    .io_dout_o   (io_dout_o),
    .bs          (bs),
    .wb          (wb),
    .src_tx_o    (src_tx),
    .src_rx_o    (src_rx),
    .src_wb_o    (src_wb),
    .irq_en_wr_o (irq_en_wr),
    .irq_en_o    (irq_en),
    .irq_pend_i  (irq_pend)
  );

  // Bit order sets vectors 1, 2, 3
  irq_ctrl u_irq_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .src_i   ({src_wb, src_rx, src_tx}),
    .en_wr_i (irq_en_wr),
    .en_i    (irq_en),
    .iack_i  (iack_i),
    .pend_o  (irq_pend),
    .irq_o   (irq_o),
    .ivec_o  (ivec_o)
  );

  wb_scratch u_wb_scratch (
    .clk   (clk),
    .rst_n (rst_n),
    .wb    (wb)
  );

endmodule

// File: verification/mcu_io_checker.sv
// ====================
// Compares DUT outputs with the value handed over for each test
// Call after a falling edge, registered outputs are settled there
// ====================
`timescale 1ns/1ps
`include "mcu_macros.svh"

module mcu_io_checker (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  io_rd_i,    // CPU read strobe
  input logic [`MCU_WIDTH-1:0] io_dout_i,
  input logic                  irq_i,
  input logic [`MCU_VEC_W-1:0] ivec_i
);

  localparam int W = `MCU_WIDTH;

  int   n_pass = 0;
  int   n_fail = 0;
  logic rd_q;  // Read strobe taken on the last edge

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) rd_q <= 1'b0;
    else        rd_q <= io_rd_i;
  end

  // irq_view picks {irq, ivec} instead of read data
  task automatic check(input string        name,
                       input logic         irq_view,
                       input logic [W-1:0] mask,
                       input logic [W-1:0] exp);
    logic [W-1:0] act;
    act = irq_view ? W'({irq_i, ivec_i}) : io_dout_i;
    act = act & mask;
    if (!irq_view && !rd_q) begin
      n_fail++;
      $display("FAIL  %s: read data checked without a read strobe", name);
    end else if (act === exp) begin
      n_pass++;
      $display("PASS  %s", name);
    end else begin
      n_fail++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Status poll gave up
  task automatic report_stuck(input string name);
    n_fail++;
    $display("FAIL  %s: status poll never reached the expected value", name);
  endtask

endmodule

// File: verification/mcu_io_assert.sv
// ====================
// Wishbone classic and interrupt vector rules bound into mcu_io
// Classic cycles only with no wait states beyond the single ack delay
// ====================
`timescale 1ns/1ps
`include "mcu_macros.svh"

module mcu_io_assert (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  cyc_i,
  input logic                  stb_i,
  input logic                  ack_i,
  input logic [`MCU_WB_AW-1:0] adr_i,
  input logic                  irq_i,
  input logic [`MCU_VEC_W-1:0] ivec_i
);

  int n_fired = 0;  // Assertion failures so far

  stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stb_i && !ack_i |=> stb_i)
    else begin
      n_fired++;
      $error("stb dropped before ack");
    end

  adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    cyc_i && !ack_i |=> $stable(adr_i))
    else begin
      n_fired++;
      $error("adr changed inside a bus cycle");
    end

  vec_irq: assert property (@(posedge clk) disable iff (!rst_n)
    (ivec_i != '0) == irq_i)
    else begin
      n_fired++;
      $error("irq and vector disagree");
    end

  // Bus idle while reset is held
  cyc_reset: assert property (@(posedge clk) !rst_n |-> !cyc_i && !stb_i)
    else begin
      n_fired++;
      $error("cyc or stb high during reset");
    end

endmodule

bind mcu_io mcu_io_assert u_assert (
  .clk    (clk),
  .rst_n  (rst_n),
  .cyc_i  (wb.cyc),
  .stb_i  (wb.stb),
  .ack_i  (wb.ack),
  .adr_i  (wb.adr),
  .irq_i  (irq_o),
  .ivec_i (ivec_o)
);

// File: verification/mcu_io_tb.sv
// ====================
// Table-driven testbench with txd_o looped straight back into rxd_i
// Entries run in order and IRQ tests rely on pending bits left earlier
// ====================
`timescale 1ns/1ps
`include "mcu_macros.svh"

module mcu_io_tb;

  localparam int W            = `MCU_WIDTH;
  localparam int ENTRY_CYCLES = 12 * `MCU_BIT_PERIOD + 20;  // Budget per entry
  localparam int POLL_MAX     = ENTRY_CYCLES / 2 - 2;       // About 2 cycles per poll
  localparam logic [W-1:0] ALL     = '1;
  localparam logic [W-1:0] ZERO    = '0;
  localparam logic [W-1:0] TX_RDY  = W'(1);   // UART_STAT bit0
  localparam logic [W-1:0] RX_FULL = W'(2);   // UART_STAT bit1
  localparam logic [W-1:0] BUSY    = W'(1);   // WB_STAT bit0

  typedef enum {OP_WR, OP_RD, OP_WAIT_BUSY, OP_WAIT_IRQ, OP_IACK} op_e;

  typedef struct {
    string                 name;
    op_e                   op;
    logic [`MCU_IO_AW-1:0] addr;
    logic [W-1:0]          data;  // Write data or compare mask
    logic [W-1:0]          exp;
  } entry_t;

  logic                  clk;
  logic                  rst_n;
  logic                  io_rd;
  logic                  io_wr;
  logic [`MCU_IO_AW-1:0] io_addr;
  logic [W-1:0]          io_din;
  logic [W-1:0]          io_dout;
  logic                  iack;
  logic                  irq;
  logic [`MCU_VEC_W-1:0] ivec;
  wire                   serial;  // Loopback line

  entry_t      tbl[$];
  logic [31:0] rng         = 32'h5435_faf7;
  bit          table_built = 1'b0;

  mcu_io DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .io_rd_i   (io_rd),
    .io_wr_i   (io_wr),
    .io_addr_i (io_addr),
    .io_din_i  (io_din),
    .io_dout_o (io_dout),
    .iack_i    (iack),
    .irq_o     (irq),
    .ivec_o    (ivec),
    .rxd_i     (serial),
    .txd_o     (serial)
  );

  mcu_io_checker u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .io_rd_i   (io_rd),
    .io_dout_i (io_dout),
    .irq_i     (irq),
    .ivec_i    (ivec)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic void add_entry(input string name, input op_e op,
                                    input logic [`MCU_IO_AW-1:0] addr,
                                    input logic [W-1:0] data, input logic [W-1:0] exp);
    entry_t e;
    e.name = name;
    e.op   = op;
    e.addr = addr;
    e.data = data;
    e.exp  = exp;
    tbl.push_back(e);
  endfunction

  // Send, wait for rx full, pop the byte, wait for tx idle
  function automatic void add_loopback(input string name, input logic [7:0] b);
    add_entry({name, "_send"}, OP_WR, mcu_pkg::UART_DATA, W'(b), ZERO);
    add_entry({name, "_rx_full"}, OP_WAIT_BUSY, mcu_pkg::UART_STAT, RX_FULL, RX_FULL);
    add_entry({name, "_byte"}, OP_RD, mcu_pkg::UART_DATA, ALL, W'(b));
    add_entry({name, "_tx_idle"}, OP_WAIT_BUSY, mcu_pkg::UART_STAT, TX_RDY, TX_RDY);
  endfunction

  // One Wishbone cycle that ends with busy clear
  function automatic void add_wb_cycle(input string name, input logic [7:0] adr,
                                       input logic we, input logic [15:0] d);
    add_entry({name, "_adr"}, OP_WR, mcu_pkg::WB_ADDR, W'(adr), ZERO);
    if (we) add_entry({name, "_dat"}, OP_WR, mcu_pkg::WB_DATA, W'(d), ZERO);
    add_entry({name, "_go"}, OP_WR, mcu_pkg::WB_CTRL, W'(we), ZERO);
    add_entry({name, "_done"}, OP_WAIT_BUSY, mcu_pkg::WB_STAT, BUSY, ZERO);
  endfunction

  function automatic void build_table();
    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [15:0] d0;
    logic [15:0] d1;
    logic [15:0] nd0;
    logic [15:0] nd1;
    b0  = 8'(next_rand());
    b1  = 8'(next_rand());
    b2  = 8'(next_rand());
    d0  = 16'(next_rand());
    d1  = 16'(next_rand());
    nd0 = ~d0;  // Alias view of reg 0
    nd1 = ~d1;
    // Reset state
    add_entry("rst_uart_stat", OP_RD, mcu_pkg::UART_STAT, ALL, TX_RDY);
    add_entry("rst_wb_stat", OP_RD, mcu_pkg::WB_STAT, ALL, ZERO);
    add_entry("rst_irq_pend", OP_RD, mcu_pkg::IRQ_PEND, ALL, ZERO);
    add_entry("rst_irq_low", OP_WAIT_IRQ, mcu_pkg::UART_DATA, ALL, ZERO);
    // Serial loopback and a second status read after the pop
    add_loopback("uart_lb", b0);
    add_entry("uart_lb_popped", OP_RD, mcu_pkg::UART_STAT, RX_FULL, ZERO);
    // Scratch registers read directly and through the inverted alias
    add_wb_cycle("wb_wr0", 8'h00, 1'b1, d0);
    add_wb_cycle("wb_wr1", 8'h01, 1'b1, d1);
    add_wb_cycle("wb_rd0", 8'h00, 1'b0, 16'h0);
    add_entry("wb_rd0_data", OP_RD, mcu_pkg::WB_DATA, ALL, W'(d0));
    add_wb_cycle("wb_rd1", 8'h01, 1'b0, 16'h0);
    add_entry("wb_rd1_data", OP_RD, mcu_pkg::WB_DATA, ALL, W'(d1));
    add_wb_cycle("wb_alias0", 8'h40, 1'b0, 16'h0);
    add_entry("wb_alias0_data", OP_RD, mcu_pkg::WB_DATA, ALL, W'(nd0));
    add_wb_cycle("wb_alias1", 8'h81, 1'b0, 16'h0);
    add_entry("wb_alias1_data", OP_RD, mcu_pkg::WB_DATA, ALL, W'(nd1));
    // Old pending bits from above are drained before the priority test
    add_entry("irq_en_all", OP_WR, mcu_pkg::IRQ_EN, W'(3'b111), ZERO);
    add_entry("irq_drain3", OP_IACK, mcu_pkg::UART_DATA, ZERO, ZERO);
    add_entry("irq_drain2", OP_IACK, mcu_pkg::UART_DATA, ZERO, ZERO);
    add_entry("irq_drain1", OP_IACK, mcu_pkg::UART_DATA, ZERO, ZERO);
    add_entry("irq_drained", OP_RD, mcu_pkg::IRQ_PEND, ALL, ZERO);
    add_loopback("irq_lb", b1);
    add_wb_cycle("irq_wb", 8'h00, 1'b0, 16'h0);
    add_entry("irq_vec3", OP_WAIT_IRQ, mcu_pkg::UART_DATA, ALL, W'({1'b1, 2'd3}));
    add_entry("irq_ack3", OP_IACK, mcu_pkg::UART_DATA, ZERO, ZERO);
    add_entry("irq_vec2", OP_WAIT_IRQ, mcu_pkg::UART_DATA, ALL, W'({1'b1, 2'd2}));
    add_entry("irq_ack2", OP_IACK, mcu_pkg::UART_DATA, ZERO, ZERO);
    add_entry("irq_vec1", OP_WAIT_IRQ, mcu_pkg::UART_DATA, ALL, W'({1'b1, 2'd1}));
    add_entry("irq_ack1", OP_IACK, mcu_pkg::UART_DATA, ZERO, ZERO);
    add_entry("irq_clear", OP_WAIT_IRQ, mcu_pkg::UART_DATA, ALL, ZERO);
    // Pending stays visible with enables off
    add_entry("mask_en_off", OP_WR, mcu_pkg::IRQ_EN, ZERO, ZERO);
    add_loopback("mask_lb", b2);
    add_wb_cycle("mask_wb", 8'h01, 1'b1, d0);
    add_entry("mask_pend", OP_RD, mcu_pkg::IRQ_PEND, ALL, W'(3'b111));
    add_entry("mask_irq_low", OP_WAIT_IRQ, mcu_pkg::UART_DATA, ALL, ZERO);
  endfunction

  task automatic bus_write(input logic [`MCU_IO_AW-1:0] addr, input logic [W-1:0] data);
    @(posedge clk);
    io_wr   <= 1'b1;
    io_addr <= addr;
    io_din  <= data;
    @(posedge clk);
    io_wr <= 1'b0;
  endtask

  task automatic bus_read(input logic [`MCU_IO_AW-1:0] addr);
    @(posedge clk);
    io_rd   <= 1'b1;
    io_addr <= addr;
    @(posedge clk);
    io_rd <= 1'b0;
    @(negedge clk);  // io_dout settled
  endtask

  task automatic run_entry(input entry_t e);
    int polls;
    polls = 0;
    case (e.op)
      OP_WR: bus_write(e.addr, e.data);
      OP_RD: begin
        bus_read(e.addr);
        u_chk.check(e.name, 1'b0, e.data, e.exp);
      end
      OP_WAIT_BUSY: begin
        bus_read(e.addr);
        while (((io_dout & e.data) != e.exp) && polls < POLL_MAX) begin
          bus_read(e.addr);
          polls++;
        end
        if ((io_dout & e.data) == e.exp) u_chk.check(e.name, 1'b0, e.data, e.exp);
        else u_chk.report_stuck(e.name);
      end
      OP_WAIT_IRQ: begin
        @(negedge clk);
        while (((W'({irq, ivec}) & e.data) != e.exp) && polls < ENTRY_CYCLES) begin
          @(negedge clk);
          polls++;
        end
        u_chk.check(e.name, 1'b1, e.data, e.exp);
      end
      OP_IACK: begin
        @(posedge clk);
        iack <= 1'b1;
        @(posedge clk);
        iack <= 1'b0;
      end
      default: u_chk.report_stuck(e.name);
    endcase
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    rst_n   = 1'b0;
    io_rd   = 1'b0;
    io_wr   = 1'b0;
    io_addr = '0;
    io_din  = '0;
    iack    = 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    foreach (tbl[i]) run_entry(tbl[i]);
    repeat (4) @(posedge clk);
    $display("Tests: %0d passed, %0d failed, %0d assertion failures",
             u_chk.n_pass, u_chk.n_fail, DUT.u_assert.n_fired);
    if (u_chk.n_fail == 0 && DUT.u_assert.n_fired == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Whole table must fit in its per-entry budget
  initial begin
    wait (table_built);
    repeat (tbl.size() * ENTRY_CYCLES + 16) @(posedge clk);
    $display("Watchdog expired before the stimulus table finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: list.f
+incdir+hw
hw/mcu_pkg.sv
hw/mcu_ifs.sv
hw/uart.sv
hw/io_regs.sv
hw/irq_ctrl.sv
hw/wb_scratch.sv
hw/mcu_io.sv
verification/mcu_io_checker.sv
verification/mcu_io_assert.sv
verification/mcu_io_tb.sv

// File: Makefile
# Verilator flow for the MCU I/O subsystem

VERILATOR  ?= verilator
TOP        := mcu_io_tb
FLIST      := list.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := SOME TESTS FAILED
PASS_MSG   := ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended early, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
